// File: Bender.yml
package:
  name: emailbox

sources:
  - rtl/mailbox_pkg.sv
  - rtl/emesh_packet_decode.sv
  - rtl/gray_ptr_counter.sv
  - rtl/mailbox_fifo_async.sv
  - rtl/mailbox_read_fsm.sv
  - rtl/mailbox_mi_regs.sv
  - rtl/emailbox_top.sv
  - target: test
    files:
      - tb/tb_emailbox.sv

// File: rtl/emailbox_top.sv
//********************
// emesh mailbox with level interrupt
// packets on wr_clk, register reads on rd_clk
// software reads LO then HI for each entry
// no back-pressure, the sender must not overrun 16 entries
// mailbox_irq mixes flags from both clocks
//********************
`timescale 1ns/1ps

module emailbox_top
#(
   parameter logic [11:0] link_id = 12'h000   // dstaddr[31:20] of this link
)
(
   input  logic                           wr_clk,
   input  logic                           rd_clk,
   input  logic                           rst_n,
   input  logic                           emesh_access,
   input  logic [mailbox_pkg::PKT_W-1:0]  emesh_packet,
   input  logic                           mi_en,
   input  logic                           mi_we,
   input  logic [mailbox_pkg::MI_AW-1:0]  mi_addr,
   input  logic                           mailbox_irq_en,
   output logic [63:0]                    mi_dout,
   output logic                           mailbox_irq
);

   import mailbox_pkg::*;

   logic        mbox_write;
   mbox_entry_t mbox_din;
   mbox_entry_t fifo_head;
   logic        fifo_empty;
   logic        fifo_full;
   logic        pop;
   logic        rd_lo;
   logic        rd_hi;
   logic        stat_clear;
   logic [31:0] lo_data;
   logic [31:0] hi_data;
   logic        hi_pending;
   logic        seq_err;

   emesh_packet_decode emesh_packet_decode_i
   (
      .wr_clk       (wr_clk),
      .rst_n        (rst_n),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .link_id      (link_id),
      .mbox_write   (mbox_write),
      .mbox_din     (mbox_din)
   );

   mailbox_fifo_async #(.entry_t(mbox_entry_t)) mailbox_fifo_async_i
   (
      .wr_clk (wr_clk),
      .rd_clk (rd_clk),
      .rst_n  (rst_n),
      .wr_en  (mbox_write),
      .din    (mbox_din),
      .rd_en  (pop),
      .dout   (fifo_head),
      .empty  (fifo_empty),
      .full   (fifo_full)
   );

   mailbox_read_fsm mailbox_read_fsm_i
   (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .rd_lo      (rd_lo),
      .rd_hi      (rd_hi),
      .stat_clear (stat_clear),
      .fifo_empty (fifo_empty),
      .fifo_head  (fifo_head),
      .pop        (pop),
      .lo_data    (lo_data),
      .hi_data    (hi_data),
      .hi_pending (hi_pending),
      .seq_err    (seq_err)
   );

   mailbox_mi_regs mailbox_mi_regs_i
   (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .lo_data    (lo_data),
      .hi_data    (hi_data),
      .hi_pending (hi_pending),
      .seq_err    (seq_err),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .rd_lo      (rd_lo),
      .rd_hi      (rd_hi),
      .stat_clear (stat_clear),
      .mi_dout    (mi_dout)
   );

   // level interrupt, stays up until software drains the FIFO
   assign mailbox_irq = mailbox_irq_en & (~fifo_empty | fifo_full);

endmodule

// File: rtl/emesh_packet_decode.sv
//********************
// combinational decode of one emesh packet
// mbox_write is a one-cycle strobe per accepted packet
// datamode and ctrlmode are not looked at
// the clock only samples the x-check assertion
//********************
`timescale 1ns/1ps

module emesh_packet_decode
(
   input  logic                           wr_clk,
   input  logic                           rst_n,
   input  logic                           emesh_access,
   input  logic [mailbox_pkg::PKT_W-1:0]  emesh_packet,
   input  logic [11:0]                    link_id,      // dstaddr[31:20] of this link
   output logic                           mbox_write,
   output mailbox_pkg::mbox_entry_t       mbox_din
);

   import mailbox_pkg::*;

   logic        pkt_write;
   logic [31:0] dstaddr;
   logic [31:0] data;
   logic [31:0] srcaddr;
   logic        id_hit;
   logic        group_hit;
   logic        reg_hit;

   // field extraction
   assign pkt_write = emesh_packet[PKT_WRITE_BIT];
   assign dstaddr   = emesh_packet[PKT_DSTADDR_LSB +: 32];
   assign data      = emesh_packet[PKT_DATA_LSB +: 32];
   assign srcaddr   = emesh_packet[PKT_SRCADDR_LSB +: 32];

   assign id_hit    = (dstaddr[31:20] == link_id);
   assign group_hit = (dstaddr[19:16] == EGROUP_MMR);
   assign reg_hit   = (dstaddr[MI_AW-1:2] == REG_MAILBOXLO); // only the low register

   assign mbox_write = emesh_access & pkt_write & id_hit & group_hit & reg_hit;

   // entry stored as {srcaddr, data}
   assign mbox_din.hi = srcaddr;
   assign mbox_din.lo = data;

   // an x on the packet would turn into a phantom or lost write
   a_pkt_known : assert property (@(posedge wr_clk) disable iff (!rst_n)
      emesh_access |-> !$isunknown(emesh_packet))
      else $error("emesh packet has unknown bits while access is high");

endmodule

// File: rtl/gray_ptr_counter.sv
//********************
// FIFO pointer, binary and Gray code
// carries one extra bit for wrap detection
// inc must already be gated by full or empty
// gray is a flop output, safe to synchronize
//********************
`timescale 1ns/1ps

module gray_ptr_counter
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             inc,
   output logic [mailbox_pkg::MBOX_PTR_W:0] bin,   // memory address plus wrap bit
   output logic [mailbox_pkg::MBOX_PTR_W:0] gray   // crosses to the other clock
);

   import mailbox_pkg::*;

   logic [MBOX_PTR_W:0] bin_next;
   logic [MBOX_PTR_W:0] gray_next;

   // next pointer, wraps through the extra bit
   assign bin_next  = bin + 1'b1;

   // binary to Gray, one bit flips per step
   assign gray_next = bin_next ^ (bin_next >> 1);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bin  <= '0;
         gray <= '0;   // gray of zero is zero
      end
      else if (inc)
      begin
         bin  <= bin_next;
         gray <= gray_next;   // registered so no glitch reaches the sync flops
      end
   end

endmodule

// File: rtl/mailbox_fifo_async.sv
//********************
// dual clock FIFO with show-ahead read
// dout is the head entry whenever empty is low
// write visible on the read side after 2 to 3 rd_clk
// full is pessimistic by the same sync delay
// writes while full and reads while empty are dropped
// one rst_n resets both domains asynchronously
//********************
`timescale 1ns/1ps

module mailbox_fifo_async
#(
   parameter type entry_t = logic [63:0]
)
(
   input  logic   wr_clk,
   input  logic   rd_clk,
   input  logic   rst_n,
   input  logic   wr_en,
   input  entry_t din,
   input  logic   rd_en,
   output entry_t dout,
   output logic   empty,
   output logic   full
);

   import mailbox_pkg::*;

   entry_t              mem [MBOX_DEPTH];   // no reset on storage

   logic [MBOX_PTR_W:0] wr_bin;
   logic [MBOX_PTR_W:0] wr_gray;
   logic [MBOX_PTR_W:0] rd_bin;
   logic [MBOX_PTR_W:0] rd_gray;

   logic [MBOX_PTR_W:0] rq1_wr_gray;   // write pointer in rd_clk domain
   logic [MBOX_PTR_W:0] rq2_wr_gray;
   logic [MBOX_PTR_W:0] wq1_rd_gray;   // read pointer in wr_clk domain
   logic [MBOX_PTR_W:0] wq2_rd_gray;

   logic                wr_inc;
   logic                rd_inc;

   assign wr_inc = wr_en & ~full;    // overflow dropped
   assign rd_inc = rd_en & ~empty;   // underflow ignored

   gray_ptr_counter wr_ptr_i
   (
      .clk   (wr_clk),
      .rst_n (rst_n),
      .inc   (wr_inc),
      .bin   (wr_bin),
      .gray  (wr_gray)
   );

   gray_ptr_counter rd_ptr_i
   (
      .clk   (rd_clk),
      .rst_n (rst_n),
      .inc   (rd_inc),
      .bin   (rd_bin),
      .gray  (rd_gray)
   );

   // storage write
   always_ff @(posedge wr_clk)
   begin
      if (wr_inc)
         mem[wr_bin[MBOX_PTR_W-1:0]] <= din;
   end

   // show-ahead, head always on dout
   assign dout = mem[rd_bin[MBOX_PTR_W-1:0]];

   // write pointer into read domain
   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rq1_wr_gray <= '0;
         rq2_wr_gray <= '0;
      end
      else
      begin
         rq1_wr_gray <= wr_gray;
         rq2_wr_gray <= rq1_wr_gray;
      end
   end

   // read pointer into write domain
   always_ff @(posedge wr_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wq1_rd_gray <= '0;
         wq2_rd_gray <= '0;
      end
      else
      begin
         wq1_rd_gray <= rd_gray;
         wq2_rd_gray <= wq1_rd_gray;
      end
   end

   // same pointer on both sides means empty
   assign empty = (rd_gray == rq2_wr_gray);

   // writer one lap ahead, top two gray bits differ
   assign full  = (wr_gray == {~wq2_rd_gray[MBOX_PTR_W -: 2],
                               wq2_rd_gray[MBOX_PTR_W-2:0]});

   a_no_overflow : assert property (@(posedge wr_clk) disable iff (!rst_n)
      !(wr_en && full))
      else $error("mailbox write while FIFO full, entry lost");

   a_no_underflow : assert property (@(posedge rd_clk) disable iff (!rst_n)
      !(rd_en && empty))
      else $error("mailbox pop while FIFO empty");

endmodule

// File: rtl/mailbox_mi_regs.sv
//********************
// mi read port for the mailbox registers
// writes on mi are ignored
// mi_dout is valid one rd_clk after the request
// any other access returns zero
//********************
`timescale 1ns/1ps

module mailbox_mi_regs
(
   input  logic                           rd_clk,
   input  logic                           rst_n,
   input  logic                           mi_en,
   input  logic                           mi_we,
   input  logic [mailbox_pkg::MI_AW-1:0]  mi_addr,
   input  logic [31:0]                    lo_data,
   input  logic [31:0]                    hi_data,
   input  logic                           hi_pending,
   input  logic                           seq_err,
   input  logic                           fifo_empty,
   input  logic                           fifo_full,
   output logic                           rd_lo,
   output logic                           rd_hi,
   output logic                           stat_clear,
   output logic [63:0]                    mi_dout
);

   import mailbox_pkg::*;

   logic                mi_rd;
   logic [MI_AW-3:0]    word_idx;
   logic                rd_stat;
   logic [31:0]         stat_word;

   assign mi_rd    = mi_en & ~mi_we;
   assign word_idx = mi_addr[MI_AW-1:2];

   // read strobes, at most one high
   assign rd_lo   = mi_rd & (word_idx == REG_MAILBOXLO);
   assign rd_hi   = mi_rd & (word_idx == REG_MAILBOXHI);
   assign rd_stat = mi_rd & (word_idx == REG_MAILBOXSTAT);

   assign stat_clear = rd_stat;   // seq_err is reported, then cleared

   always_comb
   begin
      stat_word                  = 32'h0;
      stat_word[STAT_NOT_EMPTY]  = ~fifo_empty;
      stat_word[STAT_FULL]       = fifo_full;
      stat_word[STAT_HI_PENDING] = hi_pending;
      stat_word[STAT_SEQ_ERR]    = seq_err;   // value before the clear
   end

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
         mi_dout <= 64'h0;
      else if (rd_lo)
         mi_dout <= {hi_data, lo_data};   // whole entry on a pop
      else if (rd_hi)
         mi_dout <= {32'h0, hi_data};
      else if (rd_stat)
         mi_dout <= {32'h0, stat_word};
      else
         mi_dout <= 64'h0;
   end

endmodule

// File: rtl/mailbox_pkg.sv
//********************
// shared constants for the emesh mailbox
// packet layout follows the 104-bit emesh format
// and only write, dstaddr, data and srcaddr are decoded
// FIFO depth must stay a power of two (2**MBOX_PTR_W)
// register offsets are word indices from mi_addr[7:2]
//********************
package mailbox_pkg;

   // emesh packet layout
   localparam int PKT_W           = 104;
   localparam int PKT_WRITE_BIT   = 0;    // write flag
   localparam int PKT_DSTADDR_LSB = 8;    // dstaddr in 39..8
   localparam int PKT_DATA_LSB    = 40;   // data in 71..40
   localparam int PKT_SRCADDR_LSB = 72;   // srcaddr in 103..72

   // dstaddr[19:16] group code for memory-mapped registers
   localparam logic [3:0] EGROUP_MMR = 4'hF;

   // mi register port
   localparam int MI_AW = 8;              // byte address, word index is 7..2

   localparam logic [MI_AW-3:0] REG_MAILBOXLO   = 6'h10; // pops the FIFO
   localparam logic [MI_AW-3:0] REG_MAILBOXHI   = 6'h11; // held upper half
   localparam logic [MI_AW-3:0] REG_MAILBOXSTAT = 6'h12; // status, clears seq_err

   // FIFO geometry
   localparam int MBOX_DEPTH = 16;
   localparam int MBOX_PTR_W = 4;         // address bits, pointers carry one more

   // one mailbox entry
   // hi is the sender's srcaddr, lo is the data word
   typedef struct packed
   {
      logic [31:0] hi;
      logic [31:0] lo;
   } mbox_entry_t;

   // status word bit positions
   localparam int STAT_NOT_EMPTY  = 0;
   localparam int STAT_FULL       = 1;   // pessimistic, seen through the sync delay
   localparam int STAT_HI_PENDING = 2;   // low half read, high half still waiting
   localparam int STAT_SEQ_ERR    = 3;   // sticky until a status read

endpackage

// File: rtl/mailbox_read_fsm.sv
//********************
// orders the low and high register reads
// a low read pops and parks the upper half
// out of order reads set a sticky seq_err
// lo_data and hi_data are zero outside a read
//********************
`timescale 1ns/1ps

module mailbox_read_fsm
(
   input  logic                     rd_clk,
   input  logic                     rst_n,
   input  logic                     rd_lo,
   input  logic                     rd_hi,
   input  logic                     stat_clear,
   input  logic                     fifo_empty,
   input  mailbox_pkg::mbox_entry_t fifo_head,
   output logic                     pop,
   output logic [31:0]              lo_data,
   output logic [31:0]              hi_data,     // head.hi on a pop, held word on rd_hi
   output logic                     hi_pending,
   output logic                     seq_err
);

   import mailbox_pkg::*;

   typedef enum logic {IDLE, HOLD} state_t;

   state_t      state;
   logic [31:0] hold_hi;   // upper half waiting for the high read

   assign pop        = rd_lo & ~fifo_empty;
   assign hi_pending = (state == HOLD);

   assign lo_data = pop ? fifo_head.lo : 32'h0;   // empty low read gives zero
   assign hi_data = pop                  ? fifo_head.hi :
                    (rd_hi && hi_pending) ? hold_hi      : 32'h0;

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= IDLE;
         seq_err <= 1'b0;
      end
      else
      begin
         if (stat_clear)
            seq_err <= 1'b0;
         if (pop)
         begin
            state <= HOLD;
            if (hi_pending)
               seq_err <= 1'b1;   // previous high half overwritten
         end
         else if (rd_hi)
         begin
            if (hi_pending)
               state <= IDLE;
            else
               seq_err <= 1'b1;   // high read with nothing held
         end
      end
   end

   // upper half parked by each pop
   always_ff @(posedge rd_clk)
   begin
      if (pop)
         hold_hi <= fifo_head.hi;
   end

   // strobes come from one address decode in mi_regs
   a_lo_hi_exclusive : assert property (@(posedge rd_clk) disable iff (!rst_n)
      !(rd_lo && rd_hi))
      else $error("low and high mailbox reads in the same cycle");

endmodule

// File: sources.f
rtl/mailbox_pkg.sv
rtl/emesh_packet_decode.sv
rtl/gray_ptr_counter.sv
rtl/mailbox_fifo_async.sv
rtl/mailbox_read_fsm.sv
rtl/mailbox_mi_regs.sv
rtl/emailbox_top.sv
tb/tb_emailbox.sv

// File: tb/tb_emailbox.sv
//********************
// testbench for the emesh mailbox
// rd_clk 8 ns and wr_clk 11 ns, free running
// settle after writes covers the 2 to 3 rd_clk sync delay
// stops at the first mismatch
//********************
`timescale 1ns/1ps

module tb_emailbox;

   import mailbox_pkg::*;

   localparam int          TIMEOUT_CYCLES = 60;   // per wait loop
   localparam int          SYNC_CYCLES    = 4;    // write seen on the read side by then
   localparam logic [11:0] LINK_ID        = 12'h5a3;

   logic               wr_clk;
   logic               rd_clk;
   logic               rst_n;
   logic               emesh_access;
   logic [PKT_W-1:0]   emesh_packet;
   logic               mi_en;
   logic               mi_we;
   logic [MI_AW-1:0]   mi_addr;
   logic               mailbox_irq_en;
   logic [63:0]        mi_dout;
   logic               mailbox_irq;

   integer             seed;
   mbox_entry_t        model_q[$];         // FIFO contents as the sender wrote them
   logic [31:0]        model_hold;         // upper half parked by a low read
   logic               model_hi_pending;
   logic               model_seq_err;

   emailbox_top #(.link_id(LINK_ID)) emailbox_top_i
   (
      .wr_clk         (wr_clk),
      .rd_clk         (rd_clk),
      .rst_n          (rst_n),
      .emesh_access   (emesh_access),
      .emesh_packet   (emesh_packet),
      .mi_en          (mi_en),
      .mi_we          (mi_we),
      .mi_addr        (mi_addr),
      .mailbox_irq_en (mailbox_irq_en),
      .mi_dout        (mi_dout),
      .mailbox_irq    (mailbox_irq)
   );

   always #4 rd_clk = ~rd_clk;
   always #5.5 wr_clk = ~wr_clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_dout(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_status(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_irq(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
   endtask

   // register model that updates on every read it predicts
   function automatic logic [63:0] expected_read(input logic [MI_AW-3:0] idx);
      logic [63:0] result;
      mbox_entry_t head;
      result = 64'h0;
      if (idx == REG_MAILBOXLO)
      begin
         if (model_q.size() > 0)   // empty low read returns zero and changes nothing
         begin
            head = model_q.pop_front();
            result = head;
            if (model_hi_pending)
               model_seq_err = 1'b1;   // previous upper half lost
            model_hold = head.hi;
            model_hi_pending = 1'b1;
         end
      end
      else if (idx == REG_MAILBOXHI)
      begin
         if (model_hi_pending)
         begin
            result = {32'h0, model_hold};
            model_hi_pending = 1'b0;
         end
         else
            model_seq_err = 1'b1;
      end
      else if (idx == REG_MAILBOXSTAT)
      begin
         result[STAT_NOT_EMPTY]  = (model_q.size() > 0);
         result[STAT_FULL]       = (model_q.size() == MBOX_DEPTH);
         result[STAT_HI_PENDING] = model_hi_pending;
         result[STAT_SEQ_ERR]    = model_seq_err;
         model_seq_err = 1'b0;   // reported once, then gone
      end
      return result;
   endfunction

   function automatic logic [PKT_W-1:0] make_packet(input logic wr, input logic [11:0] id,
      input logic [3:0] grp, input logic [MI_AW-3:0] idx, input logic [31:0] data,
      input logic [31:0] src);
      logic [PKT_W-1:0] pkt;
      pkt = '0;
      pkt[PKT_WRITE_BIT] = wr;
      pkt[PKT_DSTADDR_LSB +: 32] = {id, grp, 8'h00, idx, 2'b00};
      pkt[PKT_DATA_LSB +: 32] = data;
      pkt[PKT_SRCADDR_LSB +: 32] = src;
      return pkt;
   endfunction

   task automatic send_packet(input logic [PKT_W-1:0] pkt);
      @(posedge wr_clk);
      emesh_access <= 1'b1;
      emesh_packet <= pkt;
      @(posedge wr_clk);
      emesh_access <= 1'b0;   // one wr_clk access
   endtask

   task automatic push_entry();
      mbox_entry_t e;
      e.lo = $random(seed);
      e.hi = $random(seed);
      send_packet(make_packet(1'b1, LINK_ID, EGROUP_MMR, REG_MAILBOXLO, e.lo, e.hi));
      model_q.push_back(e);
   endtask

   // request on one edge, data registered on the next, sampled at the falling edge
   task automatic mi_read(input logic [MI_AW-3:0] idx, output logic [63:0] data);
      @(posedge rd_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= {idx, 2'b00};
      @(posedge rd_clk);
      mi_en   <= 1'b0;
      mi_addr <= '0;
      @(negedge rd_clk);
      data = mi_dout;
   endtask

   task automatic read_check(input logic [MI_AW-3:0] idx, input string name);
      logic [63:0] exp;
      logic [63:0] act;
      exp = expected_read(idx);
      mi_read(idx, act);
      if (idx == REG_MAILBOXSTAT)
      begin
         check_status(name, exp[31:0], act[31:0]);
         check_status({name, " upper"}, exp[63:32], act[63:32]);
      end
      else
         check_dout(name, exp, act);
   endtask

   task automatic wait_irq(input logic level, input string name);
      int n;
      n = 0;
      while (mailbox_irq !== level && n < TIMEOUT_CYCLES)
      begin
         @(negedge rd_clk);
         n++;
      end
      if (mailbox_irq !== level)
         fail_run($sformatf("timeout in %s, mailbox_irq never went to %0b", name, level));
   endtask

   // polls status while the model has no seq_err pending
   task automatic wait_status(input logic [31:0] exp, input string name);
      int n;
      logic [63:0] act;
      n = 0;
      mi_read(REG_MAILBOXSTAT, act);
      while (act[31:0] !== exp && n < TIMEOUT_CYCLES)
      begin
         mi_read(REG_MAILBOXSTAT, act);
         n++;
      end
      if (act[31:0] !== exp)
         fail_run($sformatf("timeout in %s, status stuck at %h", name, act[31:0]));
   endtask

   task automatic settle();
      repeat (SYNC_CYCLES) @(posedge rd_clk);
   endtask

   initial
   begin
      seed = 32'hec1a69f6;
      model_hold = '0;
      model_hi_pending = 1'b0;
      model_seq_err = 1'b0;
      rd_clk = 1'b0;
      wr_clk = 1'b0;
      rst_n = 1'b0;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en = 1'b0;
      mi_we = 1'b0;
      mi_addr = '0;
      mailbox_irq_en = 1'b0;
      repeat (3) @(posedge rd_clk);
      rst_n <= 1'b1;
      @(negedge rd_clk);

      // reset values
      check_dout("reset mi_dout", 64'h0, mi_dout);
      check_irq("reset irq", 1'b0, mailbox_irq);
      read_check(REG_MAILBOXSTAT, "reset status");

      // irq masked until enabled and filtered writes
      push_entry();
      wait_status(32'h1, "first write not empty");
      check_irq("irq masked", 1'b0, mailbox_irq);
      @(posedge rd_clk);
      mailbox_irq_en <= 1'b1;
      wait_irq(1'b1, "irq after enable");
      read_check(REG_MAILBOXLO, "first entry lo");
      read_check(REG_MAILBOXHI, "first entry hi");
      wait_irq(1'b0, "irq after first drain");
      send_packet(make_packet(1'b1, LINK_ID ^ 12'h001, EGROUP_MMR, REG_MAILBOXLO,
                              $random(seed), $random(seed)));
      send_packet(make_packet(1'b1, LINK_ID, 4'h3, REG_MAILBOXLO, $random(seed), $random(seed)));
      send_packet(make_packet(1'b1, LINK_ID, EGROUP_MMR, REG_MAILBOXHI,
                              $random(seed), $random(seed)));
      send_packet(make_packet(1'b0, LINK_ID, EGROUP_MMR, REG_MAILBOXLO,
                              $random(seed), $random(seed)));
      settle();
      read_check(REG_MAILBOXSTAT, "ignored writes status");
      check_irq("ignored writes irq", 1'b0, mailbox_irq);

      // FIFO order
      for (int i = 0; i < 6; i++)
         push_entry();
      settle();
      check_irq("irq with entries", 1'b1, mailbox_irq);
      for (int i = 0; i < 6; i++)
      begin
         read_check(REG_MAILBOXLO, $sformatf("order lo %0d", i));
         read_check(REG_MAILBOXHI, $sformatf("order hi %0d", i));
      end
      wait_irq(1'b0, "irq after order drain");
      read_check(REG_MAILBOXSTAT, "order drained status");

      // fill to full, then drain
      for (int i = 0; i < MBOX_DEPTH; i++)
         push_entry();
      wait_status(32'h3, "fifo full");
      read_check(REG_MAILBOXSTAT, "full status");
      for (int i = 0; i < MBOX_DEPTH; i++)
      begin
         read_check(REG_MAILBOXLO, $sformatf("full drain lo %0d", i));
         read_check(REG_MAILBOXHI, $sformatf("full drain hi %0d", i));
      end
      wait_irq(1'b0, "irq after full drain");
      wait_status(32'h0, "full clears");   // full lags by the wr_clk sync

      // sequence errors
      read_check(REG_MAILBOXHI, "hi read in idle");
      read_check(REG_MAILBOXSTAT, "seq_err from hi");
      read_check(REG_MAILBOXSTAT, "seq_err cleared");
      push_entry();
      push_entry();
      settle();
      read_check(REG_MAILBOXLO, "double lo first");
      read_check(REG_MAILBOXLO, "double lo second");
      read_check(REG_MAILBOXSTAT, "seq_err from lo");
      read_check(REG_MAILBOXSTAT, "seq_err cleared again");
      read_check(REG_MAILBOXHI, "hi after double lo");
      read_check(REG_MAILBOXSTAT, "status after hi");

      // low read on an empty FIFO
      read_check(REG_MAILBOXSTAT, "empty status before");
      read_check(REG_MAILBOXLO, "lo read on empty");
      read_check(REG_MAILBOXSTAT, "empty status after");

      $display("All tests passed!");
      $finish;
   end

endmodule
